// File: dv/lsu_stim.txt
// op addr wdata wreg wd exp_data exp_err, hex; op 0 lb 1 lh 2 lw 3 lbu 4 lhu 5 sb 6 sh 7 sw 8 pass
// op 8 passes the addr column through, exp_data is ignored for stores and error responses
8 12345678 00000000 05 1 12345678 0
7 00000010 8899aabb 01 1 00000000 0
2 00000010 00000000 02 1 8899aabb 0
0 00000010 00000000 03 1 ffffffbb 0
3 00000011 00000000 04 1 000000aa 0
0 00000012 00000000 06 1 ffffff99 0
3 00000013 00000000 07 1 00000088 0
1 00000010 00000000 08 1 ffffaabb 0
4 00000012 00000000 09 1 00008899 0
5 00000021 0000007f 0a 1 00000000 0
0 00000021 00000000 0b 1 0000007f 0
2 00000020 00000000 0c 1 00007f00 0
6 00000022 0000c001 0d 1 00000000 0
1 00000022 00000000 0e 1 ffffc001 0
4 00000022 00000000 0f 1 0000c001 0
3 00000023 00000000 10 1 000000c0 0
1 00000020 00000000 11 1 00007f00 0
2 80000010 00000000 12 1 00000000 1
7 80000020 11111111 13 1 00000000 1
2 00000020 00000000 14 1 c0017f00 0
8 deadbeef 00000000 15 0 deadbeef 0
5 00000013 12345655 16 1 00000000 0
2 00000010 00000000 17 1 5599aabb 0
0 00000013 00000000 18 0 00000055 0
4 00000010 00000000 19 1 0000aabb 0
3 00000012 00000000 1a 1 00000099 0

// File: compile.f
common/lsu_pkg.sv
common/lsu_req_if.sv
lsu/mem_access_fsm.sv
lsu/lane_formatter.sv
lsu/writeback_merge.sv
hdl/lsu_top.sv
dv/axi_slave_model.sv
dv/lsu_tb.sv

// File: dv/lsu_tb.sv
// ADDR_W fixed at 32, requests come from dv/lsu_stim.txt and are driven one at a time
`timescale 1ns/1ps
`default_nettype none

module lsu_tb import lsu_pkg::*; ();

	localparam int SEED    = 85190;
	localparam int MAX_REQ = 32;
	localparam int LIMIT   = 50;

	logic        clock = 1'b0;
	logic        rstn;
	logic        req_valid_i, req_ready_o, req_wd_i;
	lsu_op_e     req_op_i;
	logic [31:0] req_addr_i, req_wdata_i;
	logic [4:0]  req_wreg_i;
	logic [31:0] ar_addr_o, aw_addr_o, r_data_i, w_data_o;
	logic        ar_valid_o, ar_ready_i, r_valid_i, r_ready_o;
	logic        aw_valid_o, aw_ready_i, w_valid_o, w_ready_i, b_valid_i, b_ready_o;
	logic [1:0]  r_resp_i, b_resp_i;
	logic [3:0]  w_strb_o;
	logic        wb_valid_o, wb_wd_o, wb_err_o;
	logic [4:0]  wb_wreg_o;
	logic [31:0] wb_data_o;

	// seven words per request
	logic [31:0] stim [0:7*MAX_REQ-1];
	int          n_fail, n_timeout, k;
	logic        timed_out;

	always #50 clock = ~clock;

	lsu_top #(.ADDR_W(32)) i_lsu_top (.*);

	axi_slave_model #(.SEED(SEED)) i_slave (
		.clock      (clock),
		.rstn       (rstn),
		.ar_addr_i  (ar_addr_o),
		.ar_valid_i (ar_valid_o),
		.ar_ready_o (ar_ready_i),
		.r_data_o   (r_data_i),
		.r_resp_o   (r_resp_i),
		.r_valid_o  (r_valid_i),
		.r_ready_i  (r_ready_o),
		.aw_addr_i  (aw_addr_o),
		.aw_valid_i (aw_valid_o),
		.aw_ready_o (aw_ready_i),
		.w_data_i   (w_data_o),
		.w_strb_i   (w_strb_o),
		.w_valid_i  (w_valid_o),
		.w_ready_o  (w_ready_i),
		.b_resp_o   (b_resp_i),
		.b_valid_o  (b_valid_i),
		.b_ready_i  (b_ready_o)
	);

	task automatic expect_ok(input logic ok, input string msg);
		assert (ok) else begin
			$display("[FAIL] %0t ns: %s", $time, msg);
			n_fail++;
		end
	endtask

	// one strobe bit per byte, two per half, all four for a word
	function automatic logic [3:0] strobe_for(lsu_op_e op, logic [1:0] off);
		logic [3:0] s;
		int         nbytes, b, o;
		nbytes = (op == op_sb) ? 1 : ((op == op_sh) ? 2 : 4);
		o = off;
		for (b = 0; b < 4; b++)
			s[b] = (b >= o) && (b < o + nbytes);
		return s;
	endfunction

	// each enabled lane carries the store byte that belongs at that address
	function automatic logic store_lanes_ok(logic [3:0] strb, logic [1:0] off,
			logic [31:0] wdata, logic [31:0] bus);
		logic ok;
		int   b, o;
		ok = 1'b1;
		o = off;
		for (b = 0; b < 4; b++)
			if (strb[b] && (bus[8*b +: 8] !== wdata[8*(b-o) +: 8]))
				ok = 1'b0;
		return ok;
	endfunction

	task automatic run_req(input int n);
		lsu_op_e     op;
		logic [31:0] exp_data;
		logic        exp_err, exp_wd, is_ld, got;
		int          cyc;
		op       = lsu_op_e'(stim[7*n][3:0]);
		exp_data = stim[7*n+5];
		exp_err  = stim[7*n+6][0];
		is_ld    = op inside {op_lb, op_lh, op_lw, op_lbu, op_lhu};
		// only loads and pass-through write a register, never on an error response
		exp_wd   = stim[7*n+4][0] && (is_ld || op == op_pass) && !exp_err;
		@(posedge clock);
		#1;
		req_valid_i = 1'b1;
		req_op_i    = op;
		req_addr_i  = stim[7*n+1];
		req_wdata_i = stim[7*n+2];
		req_wreg_i  = stim[7*n+3][4:0];
		req_wd_i    = stim[7*n+4][0];
		cyc = 0;
		@(negedge clock);
		while (!req_ready_o && cyc < LIMIT) begin
			@(negedge clock);
			cyc++;
		end
		if (!req_ready_o) begin
			$display("timeout: request %0d was not accepted within %0d cycles", n, LIMIT);
			n_timeout++;
			timed_out = 1'b1;
			return;
		end
		// accepting edge
		@(posedge clock);
		#1;
		req_valid_i = 1'b0;
		cyc = 0;
		got = 1'b0;
		while (!got && cyc < LIMIT) begin
			@(negedge clock);
			if (wb_valid_o) begin
				got = 1'b1;
			end else begin
				expect_ok(!req_ready_o, $sformatf("req %0d: ready before write-back", n));
				if (op == op_pass)
					expect_ok(!(ar_valid_o || aw_valid_o || w_valid_o),
						$sformatf("req %0d: AXI valid raised for pass-through", n));
				if (ar_valid_o)
					expect_ok(ar_addr_o == req_addr_i,
						$sformatf("req %0d: ar addr %h", n, ar_addr_o));
				if (aw_valid_o)
					expect_ok(aw_addr_o == req_addr_i,
						$sformatf("req %0d: aw addr %h", n, aw_addr_o));
				if (w_valid_o) begin
					expect_ok(w_strb_o == strobe_for(op, req_addr_i[1:0]),
						$sformatf("req %0d: strobe %b", n, w_strb_o));
					expect_ok(store_lanes_ok(strobe_for(op, req_addr_i[1:0]),
						req_addr_i[1:0], req_wdata_i, w_data_o),
						$sformatf("req %0d: write data %h", n, w_data_o));
				end
				@(posedge clock);
				cyc++;
			end
		end
		if (!got) begin
			$display("timeout: no write-back for request %0d within %0d cycles", n, LIMIT);
			n_timeout++;
			timed_out = 1'b1;
		end else begin
			if (op == op_pass)
				expect_ok(cyc == 2, $sformatf("req %0d: pass latency %0d, expected 2", n, cyc));
			expect_ok(wb_err_o == exp_err, $sformatf("req %0d: err %b", n, wb_err_o));
			expect_ok(wb_wd_o == exp_wd, $sformatf("req %0d: wd %b", n, wb_wd_o));
			if ((is_ld || op == op_pass) && !exp_err)
				expect_ok(wb_data_o == exp_data,
					$sformatf("req %0d: data %h, expected %h", n, wb_data_o, exp_data));
			if (exp_wd)
				expect_ok(wb_wreg_o == req_wreg_i, $sformatf("req %0d: wreg %0d", n, wb_wreg_o));
			@(negedge clock);
			expect_ok(!wb_valid_o, $sformatf("req %0d: write-back longer than one cycle", n));
		end
	endtask

	initial begin
		n_fail = 0;
		n_timeout = 0;
		timed_out = 1'b0;
		rstn = 1'b0;
		req_valid_i = 1'b0;
		req_op_i = op_pass;
		req_addr_i = '0;
		req_wdata_i = '0;
		req_wreg_i = '0;
		req_wd_i = 1'b0;
		$readmemh("dv/lsu_stim.txt", stim);
		repeat (8) @(posedge clock);
		#1;
		rstn = 1'b1;
		@(negedge clock);
		expect_ok(req_ready_o && !ar_valid_o && !aw_valid_o && !w_valid_o && !wb_valid_o
			&& !r_ready_o && !b_ready_o,
			"outputs after reset");
		for (k = 0; k < MAX_REQ; k++) begin
			if (timed_out || $isunknown(stim[7*k]))
				break;
			run_req(k);
		end
		expect_ok(k > 0, "no requests read from the stimulus file");
		$display("errors: %0d check failures, %0d timeouts", n_fail, n_timeout);
		if (n_fail == 0 && n_timeout == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: dv/axi_slave_model.sv
// 256-word AXI-lite memory, word select from address bits 9:2, bit 31 set gives SLVERR
`timescale 1ns/1ps
`default_nettype none

module axi_slave_model #(
	parameter int SEED = 1
) (
	input  wire logic        clock,
	input  wire logic        rstn,
	input  wire logic [31:0] ar_addr_i,
	input  wire logic        ar_valid_i,
	output logic             ar_ready_o,
	output logic [31:0]      r_data_o,
	output logic [1:0]       r_resp_o,
	output logic             r_valid_o,
	input  wire logic        r_ready_i,
	input  wire logic [31:0] aw_addr_i,
	input  wire logic        aw_valid_i,
	output logic             aw_ready_o,
	input  wire logic [31:0] w_data_i,
	input  wire logic [3:0]  w_strb_i,
	input  wire logic        w_valid_i,
	output logic             w_ready_o,
	output logic [1:0]       b_resp_o,
	output logic             b_valid_o,
	input  wire logic        b_ready_i
);

	localparam int DEPTH = 256;
	localparam logic [1:0] OKAY = 2'b00;
	localparam logic [1:0] SLVERR = 2'b10;

	logic [31:0] mem [0:DEPTH-1];
	logic [31:0] lcg;
	// channel index 0 ar, 1 aw, 2 w
	logic [2:0]  vld, hs, rdy;
	logic        r_hs, b_hs, aw_got, w_got;
	logic [31:0] ar_a, aw_a, w_d, wr_addr, wr_word;
	logic [3:0]  w_s, wr_strb;
	int          cnt [0:2];
	int          r_cnt, b_cnt, i;

	assign ar_ready_o = rdy[0];
	assign aw_ready_o = rdy[1];
	assign w_ready_o  = rdy[2];

	// 0 to 3 cycles from a 32-bit LCG
	function automatic int rand_delay();
		lcg = lcg * 32'd1103515245 + 32'd12345;
		return int'(lcg[17:16]);
	endfunction

	initial begin
		lcg = SEED;
		rdy = 3'b000;
		r_valid_o = 1'b0;
		b_valid_o = 1'b0;
		r_data_o = '0;
		r_resp_o = OKAY;
		b_resp_o = OKAY;
		for (i = 0; i < DEPTH; i++)
			mem[i] = '0;
		forever begin
			// falling edge values hold through the next rising edge
			@(negedge clock);
			vld  = {w_valid_i, aw_valid_i, ar_valid_i};
			hs   = vld & rdy;
			r_hs = r_valid_o && r_ready_i;
			b_hs = b_valid_o && b_ready_i;
			ar_a = ar_addr_i;
			aw_a = aw_addr_i;
			w_d  = w_data_i;
			w_s  = w_strb_i;
			@(posedge clock);
			#1;
			if (!rstn) begin
				rdy = 3'b000;
				r_valid_o = 1'b0;
				b_valid_o = 1'b0;
				aw_got = 1'b0;
				w_got = 1'b0;
				r_cnt = -1;
				b_cnt = -1;
				for (i = 0; i < 3; i++)
					cnt[i] = rand_delay();
			end else begin
				// ready comes up a random number of cycles after valid
				for (i = 0; i < 3; i++) begin
					if (hs[i]) begin
						rdy[i] = 1'b0;
						cnt[i] = rand_delay();
					end else if (vld[i] && !rdy[i]) begin
						if (cnt[i] == 0)
							rdy[i] = 1'b1;
						else
							cnt[i]--;
					end
				end
				if (r_hs)
					r_valid_o = 1'b0;
				if (r_cnt == 0)
					r_valid_o = 1'b1;
				if (r_cnt >= 0)
					r_cnt--;
				if (hs[0]) begin
					r_data_o = mem[ar_a[9:2]];
					r_resp_o = ar_a[31] ? SLVERR : OKAY;
					r_cnt = rand_delay();
				end
				if (b_hs)
					b_valid_o = 1'b0;
				if (b_cnt == 0)
					b_valid_o = 1'b1;
				if (b_cnt >= 0)
					b_cnt--;
				// aw and w may arrive in either order
				if (hs[1]) begin
					wr_addr = aw_a;
					aw_got = 1'b1;
				end
				if (hs[2]) begin
					wr_word = w_d;
					wr_strb = w_s;
					w_got = 1'b1;
				end
				if (aw_got && w_got) begin
					for (i = 0; i < 4; i++)
						if (wr_strb[i] && !wr_addr[31])
							mem[wr_addr[9:2]][8*i +: 8] = wr_word[8*i +: 8];
					b_resp_o = wr_addr[31] ? SLVERR : OKAY;
					b_cnt = rand_delay();
					aw_got = 1'b0;
					w_got = 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/lsu_top.sv
// AXI-lite master, one access at a time, no size/burst/id and no write-back stall
`timescale 1ns/1ps
`default_nettype none

module lsu_top import lsu_pkg::*; #(
	parameter int ADDR_W = 32
) (
	input  wire logic              clock,
	input  wire logic              rstn,

	// request
	input  wire logic              req_valid_i,
	output logic                   req_ready_o,
	input  wire lsu_op_e           req_op_i,
	input  wire logic [ADDR_W-1:0] req_addr_i,
	input  wire logic [DATA_W-1:0] req_wdata_i,
	input  wire logic [4:0]        req_wreg_i,
	input  wire logic              req_wd_i,

	// AXI-lite read
	output logic [ADDR_W-1:0]      ar_addr_o,
	output logic                   ar_valid_o,
	input  wire logic              ar_ready_i,
	input  wire logic [DATA_W-1:0] r_data_i,
	input  wire logic [1:0]        r_resp_i,
	input  wire logic              r_valid_i,
	output logic                   r_ready_o,

	// AXI-lite write
	output logic [ADDR_W-1:0]      aw_addr_o,
	output logic                   aw_valid_o,
	input  wire logic              aw_ready_i,
	output logic [DATA_W-1:0]      w_data_o,
	output logic [STRB_W-1:0]      w_strb_o,
	output logic                   w_valid_o,
	input  wire logic              w_ready_i,
	input  wire logic [1:0]        b_resp_i,
	input  wire logic              b_valid_i,
	output logic                   b_ready_o,

	// write-back
	output logic                   wb_valid_o,
	output logic                   wb_wd_o,
	output logic [4:0]             wb_wreg_o,
	output logic [DATA_W-1:0]      wb_data_o,
	output logic                   wb_err_o
);

	logic              done;
	logic              err;
	logic [DATA_W-1:0] load_val;

	lsu_req_if #(.ADDR_W(ADDR_W)) i_req ();

	mem_access_fsm #(.ADDR_W(ADDR_W)) i_fsm (
		.clock       (clock),
		.rstn        (rstn),
		.req_valid_i (req_valid_i),
		.req_ready_o (req_ready_o),
		.req_op_i    (req_op_i),
		.req_addr_i  (req_addr_i),
		.req_wdata_i (req_wdata_i),
		.req_wreg_i  (req_wreg_i),
		.req_wd_i    (req_wd_i),
		.ar_addr_o   (ar_addr_o),
		.ar_valid_o  (ar_valid_o),
		.ar_ready_i  (ar_ready_i),
		.r_resp_i    (r_resp_i),
		.r_valid_i   (r_valid_i),
		.r_ready_o   (r_ready_o),
		.aw_addr_o   (aw_addr_o),
		.aw_valid_o  (aw_valid_o),
		.aw_ready_i  (aw_ready_i),
		.w_valid_o   (w_valid_o),
		.w_ready_i   (w_ready_i),
		.b_resp_i    (b_resp_i),
		.b_valid_i   (b_valid_i),
		.b_ready_o   (b_ready_o),
		.done_o      (done),
		.err_o       (err),
		.req         (i_req.owner)
	);

	lane_formatter #(.ADDR_W(ADDR_W)) i_fmt (
		.req        (i_req.fmt),
		.r_data_i   (r_data_i),
		.w_data_o   (w_data_o),
		.w_strb_o   (w_strb_o),
		.load_val_o (load_val)
	);

	writeback_merge i_merge (
		.clock      (clock),
		.rstn       (rstn),
		.req        (i_req.merge),
		.done_i     (done),
		.err_i      (err),
		.load_val_i (load_val),
		.wb_valid_o (wb_valid_o),
		.wb_wd_o    (wb_wd_o),
		.wb_wreg_o  (wb_wreg_o),
		.wb_data_o  (wb_data_o),
		.wb_err_o   (wb_err_o)
	);

endmodule

`default_nettype wire

// File: lsu/writeback_merge.sv
// no write-back back-pressure, the beat is valid for exactly one cycle
`timescale 1ns/1ps
`default_nettype none

module writeback_merge import lsu_pkg::*; (
	input  wire logic              clock,
	input  wire logic              rstn,
	lsu_req_if.merge               req,
	input  wire logic              done_i,
	input  wire logic              err_i,
	input  wire logic [DATA_W-1:0] load_val_i,
	output logic                   wb_valid_o,
	output logic                   wb_wd_o,
	output logic [4:0]             wb_wreg_o,
	output logic [DATA_W-1:0]      wb_data_o,
	output logic                   wb_err_o
);

	logic              is_load, is_pass;
	logic [DATA_W-1:0] pass_val;
	logic [DATA_W-1:0] data_sel;
	logic              wd_sel;

	assign is_load = op_is_load(req.op);
	assign is_pass = (req.op == op_pass);

	// pass-through value rides in the address field
	assign pass_val = DATA_W'(req.addr);

	assign data_sel = is_load ? load_val_i : (is_pass ? pass_val : '0);

	// stores and failed accesses never write a register
	assign wd_sel = req.wd && (is_load || is_pass) && !err_i;

	always_ff @(posedge clock) begin
		if (!rstn) begin
			wb_valid_o <= 1'b0;
			wb_wd_o    <= 1'b0;
			wb_err_o   <= 1'b0;
		end else begin
			wb_valid_o <= done_i;
			wb_wd_o    <= done_i && wd_sel;
			wb_err_o   <= done_i && err_i;
		end
	end

	always_ff @(posedge clock) begin
		if (done_i) begin
			wb_data_o <= data_sel;
			wb_wreg_o <= req.wreg;
		end
	end

	// one request in flight gives one beat per request
	a_done_pulse: assert property (@(posedge clock) disable iff (!rstn)
		done_i |=> !done_i);

endmodule

`default_nettype wire

// File: lsu/lane_formatter.sv
// purely combinational, assumes halfword and word accesses are naturally aligned
`timescale 1ns/1ps
`default_nettype none

module lane_formatter import lsu_pkg::*; #(
	parameter int ADDR_W = 32
) (
	lsu_req_if.fmt                req,
	input  wire logic [DATA_W-1:0] r_data_i,
	output logic [DATA_W-1:0]      w_data_o,
	output logic [STRB_W-1:0]      w_strb_o,
	output logic [DATA_W-1:0]      load_val_o
);

	logic [ADDR_W-1:0] addr;
	logic [1:0]        off;
	logic [DATA_W-1:0] shifted;
	logic              is_half, is_word;

	assign addr    = req.addr;
	assign off     = addr[1:0];
	assign is_half = req.op inside {op_lh, op_lhu, op_sh};
	assign is_word = req.op inside {op_lw, op_sw};

	// store side, data replicated so the strobe picks the lane
	always_comb begin
		w_data_o = req.wdata;
		w_strb_o = 4'b0000;
		case (req.op)
			op_sb: begin
				w_data_o = {4{req.wdata[7:0]}};
				w_strb_o = 4'b0001 << off;
			end
			op_sh: begin
				w_data_o = {2{req.wdata[15:0]}};
				w_strb_o = 4'b0011 << off;
			end
			op_sw: w_strb_o = 4'b1111;
			default: ;
		endcase
	end

	// load side, bring the addressed lane down to bit 0
	assign shifted = r_data_i >> {off, 3'b000};

	always_comb begin
		case (req.op)
			op_lb:   load_val_o = {{24{shifted[7]}}, shifted[7:0]};
			op_lbu:  load_val_o = {24'h000000, shifted[7:0]};
			op_lh:   load_val_o = {{16{shifted[15]}}, shifted[15:0]};
			op_lhu:  load_val_o = {16'h0000, shifted[15:0]};
			default: load_val_o = shifted;
		endcase
	end

	// stale requests stay aligned between accesses
	always_comb begin
		if (is_half) begin
			a_half_aligned: assert final (off[0] == 1'b0)
				else $error("misaligned halfword access at %h", addr);
		end
		if (is_word) begin
			a_word_aligned: assert final (off == 2'b00)
				else $error("misaligned word access at %h", addr);
		end
	end

endmodule

`default_nettype wire

// File: lsu/mem_access_fsm.sv
// one request in flight, misaligned addresses are not trapped, no AXI size/burst/id
`timescale 1ns/1ps
`default_nettype none

module mem_access_fsm import lsu_pkg::*; #(
	parameter int ADDR_W = 32
) (
	input  wire logic              clock,
	input  wire logic              rstn,
	input  wire logic              req_valid_i,
	output logic                   req_ready_o,
	input  wire lsu_op_e           req_op_i,
	input  wire logic [ADDR_W-1:0] req_addr_i,
	input  wire logic [DATA_W-1:0] req_wdata_i,
	input  wire logic [4:0]        req_wreg_i,
	input  wire logic              req_wd_i,
	output logic [ADDR_W-1:0]      ar_addr_o,
	output logic                   ar_valid_o,
	input  wire logic              ar_ready_i,
	input  wire logic [1:0]        r_resp_i,
	input  wire logic              r_valid_i,
	output logic                   r_ready_o,
	output logic [ADDR_W-1:0]      aw_addr_o,
	output logic                   aw_valid_o,
	input  wire logic              aw_ready_i,
	output logic                   w_valid_o,
	input  wire logic              w_ready_i,
	input  wire logic [1:0]        b_resp_i,
	input  wire logic              b_valid_i,
	output logic                   b_ready_o,
	output logic                   done_o,
	output logic                   err_o,
	lsu_req_if.owner               req
);

	lsu_state_e state_q, state_d;

	lsu_op_e           op_q;
	logic [ADDR_W-1:0] addr_q;
	logic [DATA_W-1:0] wdata_q;
	logic [4:0]        wreg_q;
	logic              wd_q;

	logic aw_done_q, w_done_q;
	logic is_load, is_store, is_pass;
	logic ar_hs, aw_hs, w_hs, r_hs, b_hs, resp_hs;
	logic addr_phase_done;

	assign is_load  = op_is_load(op_q);
	assign is_store = op_is_store(op_q);
	assign is_pass  = (op_q == op_pass);

	assign req_ready_o = (state_q == st_idle);

	// channel valids and readies depend only on state and the latched op
	assign ar_valid_o = (state_q == st_addr) && is_load;
	assign aw_valid_o = (state_q == st_addr) && is_store && !aw_done_q;
	assign w_valid_o  = (state_q == st_addr) && is_store && !w_done_q;
	assign r_ready_o  = (state_q == st_resp) && is_load;
	assign b_ready_o  = (state_q == st_resp) && is_store;
	assign ar_addr_o  = addr_q;
	assign aw_addr_o  = addr_q;

	assign ar_hs   = ar_valid_o && ar_ready_i;
	assign aw_hs   = aw_valid_o && aw_ready_i;
	assign w_hs    = w_valid_o && w_ready_i;
	assign r_hs    = r_valid_i && r_ready_o;
	assign b_hs    = b_valid_i && b_ready_o;
	assign resp_hs = r_hs || b_hs;

	// aw and w may complete in either order
	assign addr_phase_done = is_load ? ar_hs : ((aw_done_q || aw_hs) && (w_done_q || w_hs));

	// load data is only valid on the r handshake, so mem ops report there
	assign done_o = resp_hs || ((state_q == st_done) && is_pass);
	assign err_o  = (r_hs && (r_resp_i != RESP_OKAY)) || (b_hs && (b_resp_i != RESP_OKAY));

	always_comb begin
		state_d = state_q;
		case (state_q)
			st_idle: if (req_valid_i) state_d = st_addr;
			st_addr: begin
				if (is_pass)
					state_d = st_done;
				else if (addr_phase_done)
					state_d = st_resp;
			end
			st_resp: if (resp_hs) state_d = st_done;
			st_done: state_d = st_idle;
			default: state_d = st_idle;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rstn) begin
			state_q   <= st_idle;
			aw_done_q <= 1'b0;
			w_done_q  <= 1'b0;
		end else begin
			state_q <= state_d;
			if ((state_q == st_addr) && !addr_phase_done) begin
				if (aw_hs) aw_done_q <= 1'b1;
				if (w_hs) w_done_q <= 1'b1;
			end else begin
				aw_done_q <= 1'b0;
				w_done_q  <= 1'b0;
			end
		end
	end

	// request capture on acceptance
	always_ff @(posedge clock) begin
		if (req_valid_i && req_ready_o) begin
			op_q    <= req_op_i;
			addr_q  <= req_addr_i;
			wdata_q <= req_wdata_i;
			wreg_q  <= req_wreg_i;
			wd_q    <= req_wd_i;
		end
	end

	assign req.op    = op_q;
	assign req.addr  = addr_q;
	assign req.wdata = wdata_q;
	assign req.wreg  = wreg_q;
	assign req.wd    = wd_q;

	a_ar_hold: assert property (@(posedge clock) disable iff (!rstn)
		ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_addr_o));
	a_aw_hold: assert property (@(posedge clock) disable iff (!rstn)
		aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_addr_o));
	a_w_hold: assert property (@(posedge clock) disable iff (!rstn)
		w_valid_o && !w_ready_i |=> w_valid_o && $stable(wdata_q));
	a_no_rd_wr: assert property (@(posedge clock) disable iff (!rstn)
		!(ar_valid_o && aw_valid_o));

endmodule

`default_nettype wire

// File: common/lsu_req_if.sv
// holds the latched request of the single access in flight, ADDR_W must be 2 or more
`timescale 1ns/1ps
`default_nettype none

interface lsu_req_if import lsu_pkg::*; #(
	parameter int ADDR_W = 32
) ();

	lsu_op_e             op;
	logic [ADDR_W-1:0]   addr;
	logic [DATA_W-1:0]   wdata;
	logic [4:0]          wreg;
	logic                wd;

	// request register side
	modport owner (output op, addr, wdata, wreg, wd);

	// byte lane logic
	modport fmt (input op, addr, wdata);

	// write-back side, addr also carries the pass-through value
	modport merge (input op, addr, wreg, wd);

endinterface

`default_nettype wire

// File: common/lsu_pkg.sv
// RV32 only: DATA_W is fixed at 32 and the lane logic assumes four byte lanes
`default_nettype none

package lsu_pkg;

	// data path width, one RV32 word
	localparam int DATA_W = 32;
	localparam int STRB_W = DATA_W / 8;

	// AXI okay response, anything else is an error
	localparam logic [1:0] RESP_OKAY = 2'b00;

	typedef enum logic [3:0] {
		op_lb   = 4'd0,
		op_lh   = 4'd1,
		op_lw   = 4'd2,
		op_lbu  = 4'd3,
		op_lhu  = 4'd4,
		op_sb   = 4'd5,
		op_sh   = 4'd6,
		op_sw   = 4'd7,
		op_pass = 4'd8
	} lsu_op_e;

	typedef enum logic [1:0] {
		st_idle = 2'd0,
		st_addr = 2'd1,
		st_resp = 2'd2,
		st_done = 2'd3
	} lsu_state_e;

	function automatic logic op_is_load(lsu_op_e op);
		return op inside {op_lb, op_lh, op_lw, op_lbu, op_lhu};
	endfunction

	function automatic logic op_is_store(lsu_op_e op);
		return op inside {op_sb, op_sh, op_sw};
	endfunction

endpackage

`default_nettype wire
